//--- flist.f
+incdir+src
src/neurram_pkg.sv
src/neurram_ctrl_if.sv
src/neurram_apb_regs.sv
src/array_mode_decode.sv
src/wupdate_pulse_ctrl.sv
src/dac_daisy_ctrl.sv
src/neurram_top.sv
dv/tb_clk_gen.sv
dv/neurram_tb.sv

//--- Bender.yml
package:
  name: neurram_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/neurram_pkg.sv
      - src/neurram_ctrl_if.sv
      - src/neurram_apb_regs.sv
      - src/array_mode_decode.sv
      - src/wupdate_pulse_ctrl.sv
      - src/dac_daisy_ctrl.sv
      - src/neurram_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_clk_gen.sv
      - dv/neurram_tb.sv

//--- dv/neurram_tb.sv
// ----------------------------
// neurram control core testbench
// directed APB tests, DAC frame monitor
// and a reference model of the mode decode
// ----------------------------
`timescale 1ns/1ns
`include "neurram_defs.svh"

module neurram_tb import neurram_pkg::*; ();

	localparam int WAIT_LIMIT = 2000;

	logic      sys_clk;
	logic      rst_n;
	apb_addr_t paddr;
	logic      psel;
	logic      penable;
	logic      pwrite;
	reg_word_t pwdata;
	reg_word_t prdata;
	logic      pready;
	logic      pslverr;
	logic      inference_mode;
	logic      ifat_mode;
	logic      lfsr_mode;
	logic      wupdate_mode;
	logic      wupdate_pulse;
	logic      forward;
	logic      ext_3n;
	logic      ext_1n;
	logic      ext_precharge_bl;
	logic      ext_precharge_sl;
	logic      ext_inference_enable_bl;
	logic      ext_inference_enable_sl;
	logic      ext_turn_on_wl;
	logic      turn_off_precharge;
	logic      dac_sck;
	logic      dac_cs_b;
	logic      dac_sdi;

	logic [31:0] rng_state = 32'd51616;
	logic        rx_bits[$];
	logic [12:0] array_lines;
	string       line_names[13] = '{"inference_mode", "ifat_mode", "lfsr_mode",
		"wupdate_mode", "forward", "ext_3n", "ext_1n", "ext_precharge_bl",
		"ext_precharge_sl", "ext_inference_enable_bl", "ext_inference_enable_sl",
		"ext_turn_on_wl", "turn_off_precharge"};

	tb_clk_gen clk0 (.sys_clk, .rst_n);

	neurram_top dut0 (.*);

	assign array_lines = {turn_off_precharge, ext_turn_on_wl, ext_inference_enable_sl,
		ext_inference_enable_bl, ext_precharge_sl, ext_precharge_bl, ext_1n, ext_3n,
		forward, wupdate_mode, lfsr_mode, ifat_mode, inference_mode};

	// dac_sdi is held while dac_sck is high
	always @(posedge dac_sck) begin
		if (!dac_cs_b) begin
			rx_bits.push_back(dac_sdi);
		end
	end

	// ----------------------------
	// helpers
	// ----------------------------
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("CHECK FAILED time=%0t %s expected=0x%0h actual=0x%0h",
				$time, name, exp, act);
			abort_run();
		end
	endtask

	// setup phase, access phase, responses sampled mid access cycle
	task automatic apb_access(input logic wr, input apb_addr_t addr, input reg_word_t wdata,
		output reg_word_t rdata, output logic err);
		@(posedge sys_clk);
		paddr <= addr;
		pwrite <= wr;
		pwdata <= wdata;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge sys_clk);
		penable <= 1'b1;
		@(negedge sys_clk);
		check_eq("pready", 1, pready);
		rdata = prdata;
		err = pslverr;
		@(posedge sys_clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic write_reg(input apb_addr_t addr, input reg_word_t data);
		reg_word_t unused;
		logic err;
		apb_access(1'b1, addr, data, unused, err);
		check_eq("pslverr", 0, err);
	endtask

	task automatic read_reg(input apb_addr_t addr, output reg_word_t data);
		logic err;
		apb_access(1'b0, addr, '0, data, err);
		check_eq("pslverr", 0, err);
	endtask

	task automatic wait_cs(input logic level);
		int i;
		i = 0;
		while (dac_cs_b !== level && i < WAIT_LIMIT) begin
			@(negedge sys_clk);
			i++;
		end
		if (dac_cs_b !== level) begin
			$display("timeout: dac_cs_b never went to %0b", level);
			abort_run();
		end
	endtask

	// mode exclusion and precharge rules of the array decoder
	function automatic logic [12:0] expected_lines(input mode_req_t m, input ext_ctrl_t e);
		logic inf;
		logic ifat;
		logic wup;
		inf = m[0] & ~(m[1] | m[2] | m[3]);
		ifat = m[1] & ~(m[0] | m[2] | m[3]);
		wup = m[3] & ~(m[0] | m[1] | m[2]);
		return {e[7], e[4], e[3] | inf | ifat, e[2] | inf | ifat,
			e[1] | m[1] | (m[0] & m[4]), e[0] | m[1] | (m[0] & ~m[4]),
			e[5], (m[0] | m[1] | m[2]) & ~e[6], m[4], wup, m[2], ifat, inf};
	endfunction

	// ----------------------------
	// tests
	// ----------------------------
	task automatic reset_and_regs_test();
		apb_addr_t rw_addr[4] = '{`REG_CTRL_MODE, `REG_EXT_CTRL, `REG_PULSE_WIDTH,
			`REG_WMODE_WIDTH};
		reg_word_t rw_mask[4] = '{32'h1f, 32'hff, 32'hffff_ffff, 32'hffff_ffff};
		reg_word_t value;
		reg_word_t rd;
		logic err;
		int i;
		int round;
		i = 0;
		while (rst_n !== 1'b1 && i < WAIT_LIMIT) begin
			@(negedge sys_clk);
			i++;
		end
		if (rst_n !== 1'b1) begin
			$display("timeout: reset was never released");
			abort_run();
		end
		@(negedge sys_clk);
		check_eq("dac_cs_b", 1, dac_cs_b);
		check_eq("dac_sck", 0, dac_sck);
		check_eq("wupdate_pulse", 0, wupdate_pulse);
		check_eq("mode lines", 0, {inference_mode, ifat_mode, lfsr_mode, wupdate_mode});
		read_reg(`REG_STATUS, rd);
		check_eq("STATUS", 32'h6, rd);
		for (round = 0; round < 3; round++) begin
			for (i = 0; i < 4; i++) begin
				value = next_rand();
				write_reg(rw_addr[i], value);
				read_reg(rw_addr[i], rd);
				check_eq("prdata", value & rw_mask[i], rd);
			end
		end
		read_reg(`REG_CMD, rd);
		check_eq("prdata CMD", 0, rd);
		apb_access(1'b0, 8'h1C, '0, rd, err);
		check_eq("pslverr unmapped read", 1, err);
		apb_access(1'b1, 8'h40, next_rand(), rd, err);
		check_eq("pslverr unmapped write", 1, err);
		apb_access(1'b1, `REG_STATUS, next_rand(), rd, err);
		check_eq("pslverr STATUS write", 1, err);
		for (i = 0; i < 4; i++) begin
			write_reg(rw_addr[i], '0);
		end
	endtask

	task automatic mode_decode_test();
		ext_ctrl_t ext;
		logic [12:0] exp;
		int m;
		int b;
		for (m = 0; m < 32; m++) begin
			ext = ext_ctrl_t'(next_rand());
			write_reg(`REG_EXT_CTRL, reg_word_t'(ext));
			write_reg(`REG_CTRL_MODE, reg_word_t'(m));
			// register edge, then decoder output edge
			@(negedge sys_clk);
			@(negedge sys_clk);
			exp = expected_lines(mode_req_t'(m), ext);
			for (b = 0; b < 13; b++) begin
				check_eq(line_names[b], exp[b], array_lines[b]);
			end
		end
		write_reg(`REG_EXT_CTRL, '0);
		write_reg(`REG_CTRL_MODE, '0);
	endtask

	task automatic program_pulse_test();
		reg_word_t rd;
		int width;
		int i;
		width = (next_rand() % 20) + 1;
		write_reg(`REG_PULSE_WIDTH, width);
		write_reg(`REG_CMD, 32'h1 << `CMD_PROGRAM);
		// strobe cycle, pulse follows one cycle later
		@(negedge sys_clk);
		check_eq("wupdate_pulse", 0, wupdate_pulse);
		repeat (width) begin
			@(negedge sys_clk);
			check_eq("wupdate_pulse", 1, wupdate_pulse);
		end
		@(negedge sys_clk);
		check_eq("wupdate_pulse", 0, wupdate_pulse);
		read_reg(`REG_STATUS, rd);
		check_eq("STATUS.program_done", 1, rd[3]);
		check_eq("STATUS.pulse_busy", 0, rd[4]);
		// a new program command while done is ignored
		write_reg(`REG_CMD, 32'h1 << `CMD_PROGRAM);
		repeat (width + 4) begin
			@(negedge sys_clk);
			check_eq("wupdate_pulse", 0, wupdate_pulse);
		end
		read_reg(`REG_STATUS, rd);
		check_eq("STATUS.program_done", 1, rd[3]);
		write_reg(`REG_CMD, 32'h1 << `CMD_PROGRAM_ACK);
		read_reg(`REG_STATUS, rd);
		check_eq("STATUS.program_done", 0, rd[3]);
		// busy flag while a longer pulse runs
		write_reg(`REG_PULSE_WIDTH, 32'd8);
		write_reg(`REG_CMD, 32'h1 << `CMD_PROGRAM);
		read_reg(`REG_STATUS, rd);
		check_eq("STATUS.pulse_busy", 1, rd[4]);
		check_eq("STATUS.program_done", 0, rd[3]);
		i = 0;
		while (rd[3] !== 1'b1 && i < WAIT_LIMIT) begin
			read_reg(`REG_STATUS, rd);
			i++;
		end
		if (rd[3] !== 1'b1) begin
			$display("timeout: program_done never rose");
			abort_run();
		end
		write_reg(`REG_CMD, 32'h1 << `CMD_PROGRAM_ACK);
	endtask

	task automatic wmode_window_test();
		reg_word_t rd;
		int width;
		width = (next_rand() % 16) + 2;
		write_reg(`REG_CTRL_MODE, '0);
		write_reg(`REG_WMODE_WIDTH, width);
		write_reg(`REG_CMD, 32'h1 << `CMD_WMODE);
		// strobe cycle and timer edge, then decoder edge
		repeat (2) begin
			@(negedge sys_clk);
			check_eq("wupdate_mode", 0, wupdate_mode);
		end
		repeat (width) begin
			@(negedge sys_clk);
			check_eq("wupdate_mode", 1, wupdate_mode);
		end
		@(negedge sys_clk);
		check_eq("wupdate_mode", 0, wupdate_mode);
		// inference blocks the window
		write_reg(`REG_CTRL_MODE, 32'h1);
		write_reg(`REG_CMD, 32'h1 << `CMD_WMODE);
		read_reg(`REG_STATUS, rd);
		check_eq("STATUS.wmode_busy", 1, rd[5]);
		check_eq("STATUS.pulse_busy", 0, rd[4]);
		repeat (width + 3) begin
			@(negedge sys_clk);
			check_eq("wupdate_mode", 0, wupdate_mode);
			check_eq("inference_mode", 1, inference_mode);
		end
		write_reg(`REG_CTRL_MODE, '0);
	endtask

	task automatic dac_frame_test();
		dac_word_t sent[$];
		dac_word_t word;
		reg_word_t rd;
		logic err;
		int n;
		int i;
		int b;
		for (n = 1; n <= `DAC_NUM; n++) begin
			sent.delete();
			rx_bits.delete();
			for (i = 0; i < n; i++) begin
				word = dac_word_t'(next_rand());
				write_reg(`REG_DAC_DATA, reg_word_t'(word));
				sent.push_back(word);
			end
			if (n == `DAC_NUM) begin
				read_reg(`REG_STATUS, rd);
				check_eq("STATUS.fifo_full", 1, rd[0]);
				apb_access(1'b1, `REG_DAC_DATA, next_rand(), rd, err);
				check_eq("pslverr full FIFO", 1, err);
			end
			// last accepted word reads back
			read_reg(`REG_DAC_DATA, rd);
			check_eq("prdata DAC_DATA", reg_word_t'(sent[n-1]), rd);
			write_reg(`REG_CMD, 32'h1 << `CMD_DAC_UPDATE);
			wait_cs(1'b0);
			wait_cs(1'b1);
			check_eq("dac frame bit count", n * `DAC_WORD_BITS, rx_bits.size());
			for (i = 0; i < n; i++) begin
				for (b = 0; b < `DAC_WORD_BITS; b++) begin
					check_eq("dac_sdi", sent[i][`DAC_WORD_BITS-1-b],
						rx_bits[i * `DAC_WORD_BITS + b]);
				end
			end
			read_reg(`REG_STATUS, rd);
			check_eq("STATUS.dac_idle", 1, rd[2]);
			check_eq("STATUS.fifo_empty", 1, rd[1]);
		end
	endtask

	initial begin
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		reset_and_regs_test();
		mode_decode_test();
		program_pulse_test();
		wmode_window_test();
		dac_frame_test();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- dv/tb_clk_gen.sv
// ----------------------------
// testbench clock and reset
// 4 ns sys_clk, rst_n low for 16 cycles
// ----------------------------
`timescale 1ns/1ns

module tb_clk_gen (
	output logic sys_clk,
	output logic rst_n
);

	localparam int HALF_PERIOD = 2;
	localparam int RESET_CYCLES = 16;

	initial begin
		sys_clk = 1'b0;
		forever #HALF_PERIOD sys_clk = ~sys_clk;
	end

	// release on a rising edge like any other input
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		rst_n <= 1'b1;
	end

endmodule

//--- src/neurram_top.sv
// ----------------------------
// neurram host control core
// APB register bank, array mode decode,
// weight-update timer and DAC chain writer
// ----------------------------
`timescale 1ns/1ns

module neurram_top import neurram_pkg::*; (
	input  logic      sys_clk,
	input  logic      rst_n,
	// APB3 slave
	input  apb_addr_t paddr,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  reg_word_t pwdata,
	output reg_word_t prdata,
	output logic      pready,
	output logic      pslverr,
	// array control
	output logic      inference_mode,
	output logic      ifat_mode,
	output logic      lfsr_mode,
	output logic      wupdate_mode,
	output logic      wupdate_pulse,
	output logic      forward,
	output logic      ext_3n,
	output logic      ext_1n,
	output logic      ext_precharge_bl,
	output logic      ext_precharge_sl,
	output logic      ext_inference_enable_bl,
	output logic      ext_inference_enable_sl,
	output logic      ext_turn_on_wl,
	output logic      turn_off_precharge,
	// DAC chain
	output logic      dac_sck,
	output logic      dac_cs_b,
	output logic      dac_sdi
);

	neurram_ctrl_if ctrl_if ();

	neurram_apb_regs regs0 (
		.sys_clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
		.prdata, .pready, .pslverr, .ctrl(ctrl_if.regs)
	);

	array_mode_decode decode0 (
		.sys_clk, .rst_n, .ctrl(ctrl_if.decode),
		.inference_mode, .ifat_mode, .lfsr_mode, .wupdate_mode, .forward,
		.ext_3n, .ext_1n, .ext_precharge_bl, .ext_precharge_sl,
		.ext_inference_enable_bl, .ext_inference_enable_sl,
		.ext_turn_on_wl, .turn_off_precharge
	);

	wupdate_pulse_ctrl wupdate0 (
		.sys_clk, .rst_n, .ctrl(ctrl_if.wupdate), .wupdate_pulse
	);

	dac_daisy_ctrl dac0 (
		.sys_clk, .rst_n, .ctrl(ctrl_if.dac), .dac_sck, .dac_cs_b, .dac_sdi
	);

endmodule

//--- src/dac_daisy_ctrl.sv
// ----------------------------
// DAC daisy-chain writer
// word FIFO, one chip-select frame per update,
// MSB first, data sampled on rising dac_sck
// ----------------------------
`timescale 1ns/1ns
`include "neurram_defs.svh"

module dac_daisy_ctrl import neurram_pkg::*; (
	input  logic sys_clk,
	input  logic rst_n,
	neurram_ctrl_if.dac ctrl,
	output logic dac_sck,
	output logic dac_cs_b,
	output logic dac_sdi
);

	localparam int PTR_W = $clog2(`DAC_NUM);
	localparam int CNT_W = $clog2(`DAC_NUM + 1);
	localparam int BIT_W = $clog2(`DAC_WORD_BITS);
	localparam int DIV_W = $clog2(`DAC_SCK_DIV) + 1;

	dac_word_t        fifo_mem [`DAC_NUM];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fifo_cnt;
	logic             pop;
	dac_state_e       state;
	dac_word_t        shift_reg;
	logic             shift_en;
	logic [BIT_W-1:0] bit_cnt;
	logic [DIV_W-1:0] div_cnt;
	logic             div_end;
	logic             sck_q;
	logic             cs_b_q;

	// ----------------------------
	// word FIFO
	// ----------------------------
	assign pop = (state == dac_st_load);

	always_ff @(posedge sys_clk) begin
		if (ctrl.dac_push) begin
			fifo_mem[wr_ptr] <= ctrl.dac_data;
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
		end else begin
			if (ctrl.dac_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(`DAC_NUM - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(`DAC_NUM - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({ctrl.dac_push, pop})
				2'b10: fifo_cnt <= fifo_cnt + 1'b1;
				2'b01: fifo_cnt <= fifo_cnt - 1'b1;
				default: fifo_cnt <= fifo_cnt;
			endcase
		end
	end

	assign ctrl.fifo_full = (fifo_cnt == CNT_W'(`DAC_NUM));
	assign ctrl.fifo_empty = (fifo_cnt == '0);

	// ----------------------------
	// frame FSM
	// ----------------------------
	assign div_end = (div_cnt == DIV_W'(`DAC_SCK_DIV - 1));

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= dac_st_idle;
			bit_cnt <= '0;
			div_cnt <= '0;
			sck_q <= 1'b0;
			cs_b_q <= 1'b1;
		end else begin
			case (state)
				dac_st_idle: begin
					if (ctrl.dac_update && !ctrl.fifo_empty) begin
						cs_b_q <= 1'b0;
						state <= dac_st_load;
					end
				end
				dac_st_load: begin
					bit_cnt <= BIT_W'(`DAC_WORD_BITS - 1);
					div_cnt <= '0;
					state <= dac_st_shift_low;
				end
				dac_st_shift_low: begin
					if (div_end) begin
						div_cnt <= '0;
						sck_q <= 1'b1;
						state <= dac_st_shift_high;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				dac_st_shift_high: begin
					if (div_end) begin
						div_cnt <= '0;
						sck_q <= 1'b0;
						if (bit_cnt != '0) begin
							bit_cnt <= bit_cnt - 1'b1;
							state <= dac_st_shift_low;
						end else if (!ctrl.fifo_empty) begin
							// next word in the same frame
							state <= dac_st_load;
						end else begin
							state <= dac_st_frame_end;
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				dac_st_frame_end: begin
					cs_b_q <= 1'b1;
					state <= dac_st_idle;
				end
				default: state <= dac_st_idle;
			endcase
		end
	end

	// next bit moves out as sck falls
	assign shift_en = (state == dac_st_shift_high) && div_end && (bit_cnt != '0);

	always_ff @(posedge sys_clk) begin
		if (pop) begin
			shift_reg <= fifo_mem[rd_ptr];
		end else if (shift_en) begin
			shift_reg <= {shift_reg[`DAC_WORD_BITS-2:0], 1'b0};
		end
	end

	assign dac_sck = sck_q;
	assign dac_cs_b = cs_b_q;
	assign dac_sdi = shift_reg[`DAC_WORD_BITS-1];
	assign ctrl.dac_idle = (state == dac_st_idle);

	sck_only_in_frame: assert property (@(posedge sys_clk) disable iff (!rst_n)
		dac_cs_b |-> !dac_sck);

endmodule

//--- src/wupdate_pulse_ctrl.sv
// ----------------------------
// weight-update pulse timer
// programming pulse with done/ack handshake
// and the weight-update-mode window
// ----------------------------
`timescale 1ns/1ns

module wupdate_pulse_ctrl import neurram_pkg::*; (
	input  logic sys_clk,
	input  logic rst_n,
	neurram_ctrl_if.wupdate ctrl,
	output logic wupdate_pulse
);

	wup_state_e state;
	pulse_cnt_t pulse_cnt;
	pulse_cnt_t wmode_cnt;

	// ----------------------------
	// programming pulse
	// ----------------------------
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= wup_idle;
			pulse_cnt <= '0;
		end else begin
			case (state)
				wup_idle: begin
					// zero width skips straight to done
					if (ctrl.program_start) begin
						pulse_cnt <= ctrl.pulse_width - 1'b1;
						state <= (ctrl.pulse_width == '0) ? wup_done : wup_pulse;
					end
				end
				wup_pulse: begin
					if (pulse_cnt == '0) begin
						state <= wup_done;
					end else begin
						pulse_cnt <= pulse_cnt - 1'b1;
					end
				end
				wup_done: begin
					if (ctrl.program_ack) begin
						state <= wup_idle;
					end
				end
				default: state <= wup_idle;
			endcase
		end
	end

	assign wupdate_pulse = (state == wup_pulse);
	assign ctrl.pulse_busy = (state == wup_pulse);
	assign ctrl.program_done = (state == wup_done);

	// ----------------------------
	// wmode window, restarts on a new strobe
	// ----------------------------
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			wmode_cnt <= '0;
		end else if (ctrl.wmode_start) begin
			wmode_cnt <= ctrl.wmode_width;
		end else if (wmode_cnt != '0) begin
			wmode_cnt <= wmode_cnt - 1'b1;
		end
	end

	assign ctrl.wmode_active = (wmode_cnt != '0);

	pulse_done_apart: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!(wupdate_pulse && ctrl.program_done));

endmodule

//--- src/array_mode_decode.sv
// ----------------------------
// array mode decoder
// mode request and overrides to registered array
// control lines, with mode exclusion
// ----------------------------
`timescale 1ns/1ns

module array_mode_decode import neurram_pkg::*; (
	input  logic sys_clk,
	input  logic rst_n,
	neurram_ctrl_if.decode ctrl,
	output logic inference_mode,
	output logic ifat_mode,
	output logic lfsr_mode,
	output logic wupdate_mode,
	output logic forward,
	output logic ext_3n,
	output logic ext_1n,
	output logic ext_precharge_bl,
	output logic ext_precharge_sl,
	output logic ext_inference_enable_bl,
	output logic ext_inference_enable_sl,
	output logic ext_turn_on_wl,
	output logic turn_off_precharge
);

	logic      req_inference;
	logic      req_ifat;
	logic      req_lfsr;
	logic      req_wupdate;
	logic      req_forward;
	logic      inference_d;
	logic      ifat_d;
	logic      wupdate_d;
	ext_ctrl_t ext;

	assign req_inference = ctrl.mode_req[0];
	assign req_ifat = ctrl.mode_req[1];
	assign req_lfsr = ctrl.mode_req[2];
	assign req_wupdate = ctrl.mode_req[3];
	assign req_forward = ctrl.mode_req[4];
	assign ext = ctrl.ext_ctrl;

	// ----------------------------
	// exclusion rules
	// ----------------------------
	assign inference_d = req_inference & ~(req_ifat | req_lfsr | req_wupdate);
	assign ifat_d = req_ifat & ~(req_inference | req_lfsr | req_wupdate);
	// timed window from the pulse controller counts as a request
	assign wupdate_d = (req_wupdate | ctrl.wmode_active) &
		~(req_inference | req_ifat | req_lfsr);

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			inference_mode <= 1'b0;
			ifat_mode <= 1'b0;
			lfsr_mode <= 1'b0;
			wupdate_mode <= 1'b0;
			forward <= 1'b0;
			ext_3n <= 1'b0;
			ext_1n <= 1'b0;
			ext_precharge_bl <= 1'b0;
			ext_precharge_sl <= 1'b0;
			ext_inference_enable_bl <= 1'b0;
			ext_inference_enable_sl <= 1'b0;
			ext_turn_on_wl <= 1'b0;
			turn_off_precharge <= 1'b0;
		end else begin
			inference_mode <= inference_d;
			ifat_mode <= ifat_d;
			lfsr_mode <= req_lfsr;
			wupdate_mode <= wupdate_d;
			forward <= req_forward;
			// write driver on for any read-out style mode
			ext_3n <= (req_inference | req_ifat | req_lfsr) & ~ext[6];
			ext_1n <= ext[5];
			// precharge side follows the direction
			ext_precharge_bl <= ext[0] | req_ifat | (req_inference & ~req_forward);
			ext_precharge_sl <= ext[1] | req_ifat | (req_inference & req_forward);
			ext_inference_enable_bl <= ext[2] | inference_d | ifat_d;
			ext_inference_enable_sl <= ext[3] | inference_d | ifat_d;
			ext_turn_on_wl <= ext[4];
			turn_off_precharge <= ext[7];
		end
	end

	// wmode window from the timer must not leak past another mode
	mode_exclusive: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$onehot0({inference_mode, ifat_mode, lfsr_mode, wupdate_mode}));

endmodule

//--- src/neurram_apb_regs.sv
// ----------------------------
// APB register bank
// configuration registers, command strobes
// and status readback, zero wait states
// ----------------------------
`timescale 1ns/1ns
`include "neurram_defs.svh"

module neurram_apb_regs import neurram_pkg::*; (
	input  logic      sys_clk,
	input  logic      rst_n,
	input  apb_addr_t paddr,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  reg_word_t pwdata,
	output reg_word_t prdata,
	output logic      pready,
	output logic      pslverr,
	neurram_ctrl_if.regs ctrl
);

	localparam int CMD_BITS = `CMD_PROGRAM_ACK + 1;

	logic                access;
	logic                addr_hit;
	logic                wr_reject;
	logic                wr_ok;
	mode_req_t           mode_req_q;
	ext_ctrl_t           ext_ctrl_q;
	pulse_cnt_t          pulse_width_q;
	pulse_cnt_t          wmode_width_q;
	dac_word_t           dac_data_q;
	logic                dac_push_q;
	logic [CMD_BITS-1:0] cmd_q;
	reg_word_t           status;

	// ----------------------------
	// access decode
	// ----------------------------
	assign access = psel & penable;
	assign addr_hit = paddr inside {`REG_CTRL_MODE, `REG_EXT_CTRL, `REG_PULSE_WIDTH,
		`REG_WMODE_WIDTH, `REG_DAC_DATA, `REG_CMD, `REG_STATUS};

	// STATUS is read only, a push into a full FIFO is dropped
	assign wr_reject = pwrite & ((paddr == `REG_STATUS) |
		((paddr == `REG_DAC_DATA) & ctrl.fifo_full));
	assign wr_ok = access & pwrite & addr_hit & ~wr_reject;

	assign pready = 1'b1;
	assign pslverr = access & (~addr_hit | wr_reject);

	// ----------------------------
	// registers and strobes
	// ----------------------------
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_req_q <= '0;
			ext_ctrl_q <= '0;
			pulse_width_q <= '0;
			wmode_width_q <= '0;
			dac_data_q <= '0;
			dac_push_q <= 1'b0;
			cmd_q <= '0;
		end else begin
			// strobes last one cycle
			dac_push_q <= 1'b0;
			cmd_q <= '0;
			if (wr_ok) begin
				case (paddr)
					`REG_CTRL_MODE: mode_req_q <= pwdata[$bits(mode_req_t)-1:0];
					`REG_EXT_CTRL: ext_ctrl_q <= pwdata[$bits(ext_ctrl_t)-1:0];
					`REG_PULSE_WIDTH: pulse_width_q <= pwdata;
					`REG_WMODE_WIDTH: wmode_width_q <= pwdata;
					`REG_DAC_DATA: begin
						dac_data_q <= pwdata[`DAC_WORD_BITS-1:0];
						dac_push_q <= 1'b1;
					end
					`REG_CMD: cmd_q <= pwdata[CMD_BITS-1:0];
					default: ;
				endcase
			end
		end
	end

	// status bits from 0: fifo_full, fifo_empty, dac_idle,
	// program_done, pulse_busy, wmode_busy
	assign status = reg_word_t'({ctrl.wmode_active, ctrl.pulse_busy, ctrl.program_done,
		ctrl.dac_idle, ctrl.fifo_empty, ctrl.fifo_full});

	// read mux, CMD reads as zero
	always_comb begin
		case (paddr)
			`REG_CTRL_MODE: prdata = reg_word_t'(mode_req_q);
			`REG_EXT_CTRL: prdata = reg_word_t'(ext_ctrl_q);
			`REG_PULSE_WIDTH: prdata = pulse_width_q;
			`REG_WMODE_WIDTH: prdata = wmode_width_q;
			`REG_DAC_DATA: prdata = reg_word_t'(dac_data_q);
			`REG_STATUS: prdata = status;
			default: prdata = '0;
		endcase
	end

	// to the blocks
	assign ctrl.mode_req = mode_req_q;
	assign ctrl.ext_ctrl = ext_ctrl_q;
	assign ctrl.pulse_width = pulse_width_q;
	assign ctrl.wmode_width = wmode_width_q;
	assign ctrl.dac_data = dac_data_q;
	assign ctrl.dac_push = dac_push_q;
	assign ctrl.dac_update = cmd_q[`CMD_DAC_UPDATE];
	assign ctrl.program_start = cmd_q[`CMD_PROGRAM];
	assign ctrl.wmode_start = cmd_q[`CMD_WMODE];
	assign ctrl.program_ack = cmd_q[`CMD_PROGRAM_ACK];

	// APB access phases never come back to back
	strobe_one_cycle: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(|{cmd_q, dac_push_q}) |=> !(|{cmd_q, dac_push_q}));

endmodule

//--- src/neurram_ctrl_if.sv
// ----------------------------
// control bus between register bank and blocks
// configuration, strobes and status flags
// ----------------------------
`timescale 1ns/1ns

interface neurram_ctrl_if import neurram_pkg::*; ();

	// configuration from the register bank
	mode_req_t  mode_req;
	ext_ctrl_t  ext_ctrl;
	pulse_cnt_t pulse_width;
	pulse_cnt_t wmode_width;

	// one-cycle strobes
	logic       program_start;
	logic       wmode_start;
	logic       program_ack;
	logic       dac_push;
	dac_word_t  dac_data;
	logic       dac_update;

	// weight-update timer status
	logic       wmode_active;
	logic       pulse_busy;
	logic       program_done;

	// DAC writer status
	logic       fifo_full;
	logic       fifo_empty;
	logic       dac_idle;

	modport regs (
		output mode_req, ext_ctrl, pulse_width, wmode_width,
		output program_start, wmode_start, program_ack,
		output dac_push, dac_data, dac_update,
		input  wmode_active, pulse_busy, program_done,
		input  fifo_full, fifo_empty, dac_idle
	);

	modport decode (
		input  mode_req, ext_ctrl, wmode_active
	);

	modport wupdate (
		input  pulse_width, wmode_width, program_start, wmode_start, program_ack,
		output wmode_active, pulse_busy, program_done
	);

	modport dac (
		input  dac_push, dac_data, dac_update,
		output fifo_full, fifo_empty, dac_idle
	);

endinterface

//--- src/neurram_pkg.sv
// ----------------------------
// neurram control core types
// shared vectors and FSM encodings
// ----------------------------
`include "neurram_defs.svh"

package neurram_pkg;

	// APB side
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] reg_word_t;

	// pulse length in sys_clk cycles
	typedef logic [31:0] pulse_cnt_t;

	typedef logic [`DAC_WORD_BITS-1:0] dac_word_t;

	// inference, ifat, lfsr, wupdate, forward from bit 0
	typedef logic [4:0] mode_req_t;

	// override mask, bit 0 upward
	// precharge_bl, precharge_sl, inference_enable_bl, inference_enable_sl,
	// turn_on_wl, ext_1n, ext_3n_disable, turn_off_precharge
	typedef logic [7:0] ext_ctrl_t;

	// ----------------------------
	// FSM encodings
	// ----------------------------
	typedef enum logic [1:0] {
		wup_idle,
		wup_pulse,
		wup_done
	} wup_state_e;

	typedef enum logic [2:0] {
		dac_st_idle,
		dac_st_load,
		dac_st_shift_low,
		dac_st_shift_high,
		dac_st_frame_end
	} dac_state_e;

endpackage

//--- src/neurram_defs.svh
// ----------------------------
// neurram control core constants
// register map, command bits and DAC chain sizing
// ----------------------------
`ifndef NEURRAM_DEFS_SVH
`define NEURRAM_DEFS_SVH

// APB register byte offsets
`define REG_CTRL_MODE   8'h00
`define REG_EXT_CTRL    8'h04
`define REG_PULSE_WIDTH 8'h08
`define REG_WMODE_WIDTH 8'h0C
`define REG_DAC_DATA    8'h10
`define REG_CMD         8'h14
`define REG_STATUS      8'h18

// bit positions in CMD
`define CMD_DAC_UPDATE  0
`define CMD_PROGRAM     1
`define CMD_WMODE       2
`define CMD_PROGRAM_ACK 3

// DAC daisy chain, also the FIFO depth
`define DAC_NUM         4
`define DAC_WORD_BITS   32
// sys_clk cycles per half period of dac_sck
`define DAC_SCK_DIV     2

`endif
